// ==== Makefile ====
VERILATOR = verilator
FLAGS     = --binary --timing --assert -j 0
TOP       = tb_servo
FILELIST  = all.f
BUILD_DIR = obj_dir
PASS_MSG  = *** TEST PASSED ***

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee /dev/stderr | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// ==== all.f ====
rtl/servo_pkg.sv
rtl/adc_sample_capture.sv
rtl/iir_first_order.sv
rtl/dac_word_formatter.sv
rtl/servo_datapath_top.sv
testbench/servo_properties.sv
testbench/servo_checker.sv
testbench/tb_servo.sv

// ==== rtl/adc_sample_capture.sv ====
// i_config is sampled on every clock and should only change while no samples flow
// samples are left-aligned with zero fill, so the low bits start out clear
`timescale 1ns/1ps

module adc_sample_capture (
	input  logic                                         clk1,
	input  logic                                         i_arst_n,
	input  logic                                         i_adc_valid,
	input  servo_pkg::adc_pair_t                         i_adc,
	input  servo_pkg::servo_config_t                     i_config,
	output logic                                         o_valid,
	output servo_pkg::sample_pair_t                      o_samples,
	output servo_pkg::filter_coeffs_t [servo_pkg::NUM_CHANNELS-1:0] o_coeffs
);

	import servo_pkg::*;

	localparam int PAD_WIDTH = SIGNAL_WIDTH - ADC_WIDTH;

	// working copy of the filter settings
	servo_config_t config_q;
	sample_pair_t  samples_q;
	logic          valid_q;

	////////////////////
	// configuration register

	// free-running copy of the host settings
	always_ff @(posedge clk1) begin
		config_q <= i_config;
	end

	////////////////////
	// sample register

	// widen on the way in
	always_ff @(posedge clk1) begin
		if (i_adc_valid) begin
			samples_q.ch0 <= {i_adc.ch0, {PAD_WIDTH{1'b0}}};
			samples_q.ch1 <= {i_adc.ch1, {PAD_WIDTH{1'b0}}};
		end
	end

	// strobe follows the sample by one cycle
	always_ff @(posedge clk1 or negedge i_arst_n) begin
		if (!i_arst_n) begin
			valid_q <= 1'b0;
		end else begin
			valid_q <= i_adc_valid;
		end
	end

	assign o_valid   = valid_q;
	assign o_samples = samples_q;

	// one settings slice per filter lane
	always_comb begin
		for (int ch = 0; ch < NUM_CHANNELS; ch++) begin
			o_coeffs[ch] = config_q[ch];
		end
	end

endmodule

// ==== rtl/dac_word_formatter.sv ====
// both DAC words are plain truncations of the 24-bit results, no rounding
// dac1 carries ch0 - ch1 with wrap, so large opposite inputs fold over
`timescale 1ns/1ps

module dac_word_formatter (
	input  logic                    clk1,
	input  logic                    i_arst_n,
	input  logic                    i_valid,
	input  servo_pkg::sample_pair_t i_samples,
	output logic                    o_dac_valid,
	output servo_pkg::dac_pair_t    o_dac
);

	import servo_pkg::*;

	logic signed [SIGNAL_WIDTH-1:0] diff;
	dac_pair_t                      dac_next;
	dac_pair_t                      dac_q;
	logic                           valid_q;

	////////////////////
	// difference and high words

	always_comb begin
		// wraps at SIGNAL_WIDTH
		diff = i_samples.ch0 - i_samples.ch1;
		// low bits of the path never reach the DAC
		dac_next.dac0 = i_samples.ch0[SIGNAL_WIDTH-1 -: DAC_WIDTH];
		dac_next.dac1 = diff[SIGNAL_WIDTH-1 -: DAC_WIDTH];
	end

	////////////////////
	// output register

	// words hold between strobes
	always_ff @(posedge clk1 or negedge i_arst_n) begin
		if (!i_arst_n) begin
			dac_q   <= '0;
			valid_q <= 1'b0;
		end else begin
			valid_q <= i_valid;
			if (i_valid) begin
				dac_q <= dac_next;
			end
		end
	end

	assign o_dac_valid = valid_q;
	assign o_dac       = dac_q;

endmodule

// ==== rtl/iir_first_order.sv ====
// y = b0*x + b1*x_prev + a1*y_prev, shifted down by COEF_FRAC and wrapped
// state only moves on i_valid; bypass still loads x_prev and y_prev
`timescale 1ns/1ps

module iir_first_order (
	input  logic                                  clk1,
	input  logic                                  i_arst_n,
	input  logic                                  i_valid,
	input  logic signed [servo_pkg::SIGNAL_WIDTH-1:0] i_sample,
	input  servo_pkg::filter_coeffs_t             i_coeffs,
	output logic                                  o_valid,
	output logic signed [servo_pkg::SIGNAL_WIDTH-1:0] o_sample
);

	import servo_pkg::*;

	// coefficient fields, unpacked for signed math
	logic signed [COEF_WIDTH-1:0] b0;
	logic signed [COEF_WIDTH-1:0] b1;
	logic signed [COEF_WIDTH-1:0] a1;

	// channel history
	logic signed [SIGNAL_WIDTH-1:0] x_prev;
	// doubles as the registered output
	logic signed [SIGNAL_WIDTH-1:0] y_q;
	logic                           valid_q;

	// full-precision sum of products
	logic signed [ACC_WIDTH-1:0]    acc;
	logic signed [SIGNAL_WIDTH-1:0] y_filt;
	logic signed [SIGNAL_WIDTH-1:0] y_next;

	assign b0 = i_coeffs.b0;
	assign b1 = i_coeffs.b1;
	assign a1 = i_coeffs.a1;

	////////////////////
	// recursion

	always_comb begin
		// all terms sign-extended to ACC_WIDTH before the multiply
		acc = b0 * i_sample + b1 * x_prev + a1 * y_q;
		// arithmetic shift then wrap, same as a slice
		y_filt = acc[COEF_FRAC +: SIGNAL_WIDTH];
		if (i_coeffs.on) begin
			y_next = y_filt;
		end else begin
			// bypass
			y_next = i_sample;
		end
	end

	////////////////////
	// state

	always_ff @(posedge clk1 or negedge i_arst_n) begin
		if (!i_arst_n) begin
			x_prev  <= '0;
			y_q     <= '0;
			valid_q <= 1'b0;
		end else begin
			valid_q <= i_valid;
			// hold history across gaps between samples
			if (i_valid) begin
				x_prev <= i_sample;
				y_q    <= y_next;
			end
		end
	end

	assign o_valid  = valid_q;
	assign o_sample = y_q;

endmodule

// ==== rtl/servo_datapath_top.sv ====
// three cycles from i_adc_valid to o_dac_valid, no back-pressure
// i_config should only change after the strobe has been idle for 5 cycles
`timescale 1ns/1ps

module servo_datapath_top (
	input  logic                      clk1,
	input  logic                      i_arst_n,
	input  logic                      i_adc_valid,
	input  servo_pkg::adc_pair_t      i_adc,
	input  servo_pkg::servo_config_t  i_config,
	output logic                      o_dac_valid,
	output servo_pkg::dac_pair_t      o_dac
);

	import servo_pkg::*;

	// capture to filters
	logic           cap_valid;
	sample_pair_t   cap_samples;
	filter_coeffs_t [NUM_CHANNELS-1:0] cap_coeffs;

	// filters to formatter
	logic           filt_valid;
	sample_pair_t   filt_samples;

	////////////////////
	// stage 1

	adc_sample_capture adc_sample_capture_inst (
		.clk1        (clk1),
		.i_arst_n    (i_arst_n),
		.i_adc_valid (i_adc_valid),
		.i_adc       (i_adc),
		.i_config    (i_config),
		.o_valid     (cap_valid),
		.o_samples   (cap_samples),
		.o_coeffs    (cap_coeffs)
	);

	////////////////////
	// stage 2

	iir_first_order iir_ch0_inst (
		.clk1     (clk1),
		.i_arst_n (i_arst_n),
		.i_valid  (cap_valid),
		.i_sample (cap_samples.ch0),
		.i_coeffs (cap_coeffs[0]),
		.o_valid  (filt_valid),
		.o_sample (filt_samples.ch0)
	);

	// valid matches ch0, left open
	iir_first_order iir_ch1_inst (
		.clk1     (clk1),
		.i_arst_n (i_arst_n),
		.i_valid  (cap_valid),
		.i_sample (cap_samples.ch1),
		.i_coeffs (cap_coeffs[1]),
		.o_valid  (),
		.o_sample (filt_samples.ch1)
	);

	////////////////////
	// stage 3

	dac_word_formatter dac_word_formatter_inst (
		.clk1        (clk1),
		.i_arst_n    (i_arst_n),
		.i_valid     (filt_valid),
		.i_samples   (filt_samples),
		.o_dac_valid (o_dac_valid),
		.o_dac       (o_dac)
	);

endmodule

// ==== rtl/servo_pkg.sv ====
// widths and shared types for the two-channel servo datapath
// coefficients are signed fixed point with COEF_FRAC fraction bits
package servo_pkg;

	////////////////////
	// widths

	// raw converter sample
	localparam int ADC_WIDTH = 16;
	// internal signal path
	localparam int SIGNAL_WIDTH = 24;
	// fast DAC word
	localparam int DAC_WIDTH = 16;
	localparam int COEF_WIDTH = 18;
	// 1.0 is 2**COEF_FRAC
	localparam int COEF_FRAC = 16;
	localparam int NUM_CHANNELS = 2;

	// three coefficient products summed without overflow
	localparam int ACC_WIDTH = COEF_WIDTH + SIGNAL_WIDTH + 2;

	////////////////////
	// datapath types

	// raw sample pair as it comes off the ADC
	typedef struct packed {
		logic signed [ADC_WIDTH-1:0] ch0;
		logic signed [ADC_WIDTH-1:0] ch1;
	} adc_pair_t;

	// both lanes at working width
	typedef struct packed {
		logic signed [SIGNAL_WIDTH-1:0] ch0;
		logic signed [SIGNAL_WIDTH-1:0] ch1;
	} sample_pair_t;

	// one channel's low-pass settings
	typedef struct packed {
		logic on;
		logic signed [COEF_WIDTH-1:0] b0;
		logic signed [COEF_WIDTH-1:0] b1;
		logic signed [COEF_WIDTH-1:0] a1;
	} filter_coeffs_t;

	// index 0 is channel 0
	typedef filter_coeffs_t [NUM_CHANNELS-1:0] servo_config_t;

	// words for the fast DAC
	typedef struct packed {
		logic signed [DAC_WIDTH-1:0] dac0;
		logic signed [DAC_WIDTH-1:0] dac1;
	} dac_pair_t;

endpackage

// ==== testbench/servo_checker.sv ====
// samples DUT ports on the rising edge; inputs must be stable there
// expected words are queued per strobe, so any latency is accepted here
`timescale 1ns/1ps

module servo_checker (
	input  logic                     clk1,
	input  logic                     i_arst_n,
	input  logic                     i_adc_valid,
	input  servo_pkg::adc_pair_t     i_adc,
	input  servo_pkg::servo_config_t i_config,
	input  logic                     i_dac_valid,
	input  servo_pkg::dac_pair_t     i_dac,
	output int                       o_mismatches,
	output int                       o_unexpected,
	output int                       o_pending
);

	import servo_pkg::*;

	// reference state per channel
	logic signed [SIGNAL_WIDTH-1:0] x_prev0, x_prev1;
	logic signed [SIGNAL_WIDTH-1:0] y_prev0, y_prev1;
	logic signed [SIGNAL_WIDTH-1:0] x0, x1, y0, y1, diff;
	dac_pair_t                      want;
	dac_pair_t                      expected_q[$];
	logic                           seen_output;

	// left-align, zero fill
	function automatic logic signed [SIGNAL_WIDTH-1:0] widen(input logic signed [ADC_WIDTH-1:0] s);
		return {s, {(SIGNAL_WIDTH - ADC_WIDTH){1'b0}}};
	endfunction

	// one step of the first-order recursion, full precision then wrap
	function automatic logic signed [SIGNAL_WIDTH-1:0] filter_step(
		input filter_coeffs_t                 c,
		input logic signed [SIGNAL_WIDTH-1:0] x,
		input logic signed [SIGNAL_WIDTH-1:0] xp,
		input logic signed [SIGNAL_WIDTH-1:0] yp
	);
		longint acc;
		longint shifted;
		acc = longint'(c.b0) * longint'(x) + longint'(c.b1) * longint'(xp);
		acc = acc + longint'(c.a1) * longint'(yp);
		shifted = acc >>> COEF_FRAC;
		if (c.on) begin
			return shifted[SIGNAL_WIDTH-1:0];
		end
		return x;
	endfunction

	initial begin
		o_mismatches = 0;
		o_unexpected = 0;
		o_pending = 0;
		seen_output = 1'b0;
	end

	////////////////////
	// compare and predict

	always @(posedge clk1) begin
		if (!i_arst_n) begin
			x_prev0 = '0;
			x_prev1 = '0;
			y_prev0 = '0;
			y_prev1 = '0;
			expected_q.delete();
		end else begin
			if (i_dac_valid) begin
				seen_output = 1'b1;
				if (expected_q.size() == 0) begin
					$display("unexpected DAC output at %0t with nothing expected", $time);
					o_unexpected++;
				end else begin
					want = expected_q.pop_front();
					if (i_dac !== want) begin
						$display("ERR %0t: dac0/dac1 = %h/%h, expected %h/%h", $time,
							i_dac.dac0, i_dac.dac1, want.dac0, want.dac1);
						o_mismatches++;
					end
				end
			end else if (!seen_output && i_dac !== '0) begin
				// outputs must stay clear until the first result
				$display("ERR %0t: o_dac = %h before any result", $time, i_dac);
				o_mismatches++;
			end
			if (i_adc_valid) begin
				x0 = widen(i_adc.ch0);
				x1 = widen(i_adc.ch1);
				y0 = filter_step(i_config[0], x0, x_prev0, y_prev0);
				y1 = filter_step(i_config[1], x1, x_prev1, y_prev1);
				x_prev0 = x0;
				x_prev1 = x1;
				y_prev0 = y0;
				y_prev1 = y1;
				diff = y0 - y1;
				want.dac0 = y0[SIGNAL_WIDTH-1 -: DAC_WIDTH];
				want.dac1 = diff[SIGNAL_WIDTH-1 -: DAC_WIDTH];
				expected_q.push_back(want);
			end
		end
		o_pending = expected_q.size();
	end

endmodule

// ==== testbench/servo_properties.sv ====
// bound to servo_datapath_top, checks latency and bypass identity
// config is assumed steady around samples, so a 3-cycle $past of it is used
`timescale 1ns/1ps

module servo_properties (
	input logic                     clk1,
	input logic                     i_arst_n,
	input logic                     i_adc_valid,
	input servo_pkg::adc_pair_t     i_adc,
	input servo_pkg::servo_config_t i_config,
	input logic                     i_dac_valid,
	input servo_pkg::dac_pair_t     i_dac
);

	// no output strobe while held in reset
	a_reset_quiet: assert property (@(posedge clk1) !i_arst_n |-> !i_dac_valid)
		else $error("o_dac_valid high during reset");

	// fixed three-stage pipeline
	a_latency: assert property (@(posedge clk1) disable iff (!i_arst_n)
		i_dac_valid == $past(i_adc_valid, 3))
		else $error("o_dac_valid does not follow i_adc_valid by 3 cycles");

	// both lanes bypassed, dac0 is the raw ch0 sample
	a_bypass: assert property (@(posedge clk1) disable iff (!i_arst_n)
		(i_dac_valid && !$past(i_config[0].on, 3) && !$past(i_config[1].on, 3))
		|-> i_dac.dac0 == $past(i_adc.ch0, 3))
		else $error("bypassed dac0 differs from channel 0 input");

endmodule

bind servo_datapath_top servo_properties servo_properties_inst (
	.clk1        (clk1),
	.i_arst_n    (i_arst_n),
	.i_adc_valid (i_adc_valid),
	.i_adc       (i_adc),
	.i_config    (i_config),
	.i_dac_valid (o_dac_valid),
	.i_dac       (o_dac)
);

// ==== testbench/tb_servo.sv ====
// stimulus changes 2 ns after the rising edge; config only moves while idle
// run is capped by a cycle counter sized from the phase lengths
`timescale 1ns/1ps

module tb_servo;

	import servo_pkg::*;

	localparam int PHASE_SAMPLES = 200;
	// four phases, sparse one up to 4 cycles per sample, plus gaps
	localparam int MAX_CYCLES = 4 * PHASE_SAMPLES * 2 + 400;

	logic            clk1;
	logic            i_arst_n;
	logic            i_adc_valid;
	adc_pair_t       i_adc;
	servo_config_t   i_config;
	logic            o_dac_valid;
	dac_pair_t       o_dac;
	int              mismatches, unexpected, pending;
	int              cycle_count;
	integer          seed;
	logic [31:0]     rnd;
	adc_pair_t       pair;
	servo_config_t   cfg;

	servo_datapath_top servo_datapath_top_inst (
		.clk1        (clk1),
		.i_arst_n    (i_arst_n),
		.i_adc_valid (i_adc_valid),
		.i_adc       (i_adc),
		.i_config    (i_config),
		.o_dac_valid (o_dac_valid),
		.o_dac       (o_dac)
	);

	servo_checker servo_checker_inst (
		.clk1         (clk1),
		.i_arst_n     (i_arst_n),
		.i_adc_valid  (i_adc_valid),
		.i_adc        (i_adc),
		.i_config     (i_config),
		.i_dac_valid  (o_dac_valid),
		.i_dac        (o_dac),
		.o_mismatches (mismatches),
		.o_unexpected (unexpected),
		.o_pending    (pending)
	);

	////////////////////
	// clock and timeout

	initial begin
		clk1 = 1'b0;
		forever #20 clk1 = ~clk1;
	end

	initial begin
		cycle_count = 0;
		while (cycle_count < MAX_CYCLES) begin
			@(posedge clk1);
			cycle_count++;
		end
		$display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
		$display("*** TEST FAILED ***");
		$finish;
	end

	////////////////////
	// drive helpers

	task automatic drive_sample(input adc_pair_t p);
		@(posedge clk1);
		#2;
		i_adc_valid = 1'b1;
		i_adc = p;
	endtask

	task automatic idle_for(input int n);
		repeat (n) begin
			@(posedge clk1);
			#2;
			i_adc_valid = 1'b0;
		end
	endtask

	// at least 5 idle cycles on both sides of a change
	task automatic load_config(input servo_config_t c);
		idle_for(6);
		i_config = c;
		idle_for(4);
	endtask

	task automatic random_pair(output adc_pair_t p);
		rnd = $random(seed);
		p.ch0 = rnd[15:0];
		p.ch1 = rnd[31:16];
	endtask

	function automatic filter_coeffs_t make_coeffs(input logic on,
		input logic signed [COEF_WIDTH-1:0] b0, input logic signed [COEF_WIDTH-1:0] b1,
		input logic signed [COEF_WIDTH-1:0] a1);
		filter_coeffs_t c;
		c.on = on;
		c.b0 = b0;
		c.b1 = b1;
		c.a1 = a1;
		return c;
	endfunction

	////////////////////
	// phases

	initial begin
		seed = 32'hf7ff_3ca2;
		i_arst_n = 1'b0;
		i_adc_valid = 1'b0;
		i_adc = '0;
		i_config = '0;
		repeat (4) @(posedge clk1);
		#2;
		i_arst_n = 1'b1;
		// outputs must stay quiet here
		idle_for(10);

		// bypass, coefficients ignored
		cfg[0] = make_coeffs(1'b0, 18'sd3277, 18'sd3277, 18'sd58982);
		cfg[1] = make_coeffs(1'b0, -18'sd500, 18'sd700, 18'sd1000);
		load_config(cfg);
		repeat (PHASE_SAMPLES) begin
			random_pair(pair);
			drive_sample(pair);
		end

		// low-pass, b0 = b1 ~ 0.05, a1 ~ 0.9
		cfg[0] = make_coeffs(1'b1, 18'sd3277, 18'sd3277, 18'sd58982);
		cfg[1] = make_coeffs(1'b1, 18'sd3277, 18'sd3277, 18'sd58982);
		load_config(cfg);
		for (int i = 0; i < PHASE_SAMPLES; i++) begin
			pair.ch0 = (i < 10) ? 16'sd0 : 16'sd12000;
			pair.ch1 = (i < 10) ? 16'sd0 : -16'sd8000;
			drive_sample(pair);
		end

		// same filters, random gaps between strobes
		idle_for(3);
		repeat (PHASE_SAMPLES) begin
			random_pair(pair);
			drive_sample(pair);
			rnd = $random(seed);
			idle_for(int'(rnd[1:0]));
		end

		// ch0 unstable and wrapping, ch1 bypassed
		cfg[0] = make_coeffs(1'b1, 18'sd131071, -18'sd100000, 18'sd120000);
		cfg[1] = make_coeffs(1'b0, 18'sd0, 18'sd0, 18'sd0);
		load_config(cfg);
		repeat (PHASE_SAMPLES) begin
			random_pair(pair);
			drive_sample(pair);
		end

		// drain the pipeline
		idle_for(10);
		if (pending != 0) begin
			$display("checker still expected %0d DAC words when the run ended", pending);
		end
		$display("errors: %0d mismatched, %0d unexpected, %0d missing",
			mismatches, unexpected, pending);
		if (mismatches + unexpected + pending == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule
